// ==== logic/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [3:0] lc3b_imm4;
typedef logic [4:0] lc3b_imm5;
typedef logic [5:0] lc3b_offset6;

localparam int mdu_steps = 16;                  // Iterations per MUL or DIV
localparam int mdu_cnt_w = $clog2(mdu_steps);
localparam int reg_count = 8;

typedef enum logic [3:0] {
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_str = 4'b0111,
	op_not = 4'b1001,
	op_shf = 4'b1010,                           // Off 1101, which carries MUL/DIV
	op_mdu = 4'b1101                            // Bit 5 clear MUL, set DIV
} lc3b_opcode;

typedef enum logic [3:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_sll,
	alu_srl,
	alu_sra,
	alu_pass,
	alu_mult,
	alu_div
} lc3b_aluop;

// B operand source
typedef enum logic [1:0] {
	sel_sr2,
	sel_sext5,
	sel_adj6,
	sel_zext4
} lc3b_alumux_sel;

// Instructions that write DR in bits 11..9
function automatic logic writes_dr(lc3b_word ir);
	lc3b_opcode opcode;
	opcode = lc3b_opcode'(ir[15:12]);
	case (opcode)
		op_add, op_and, op_not, op_shf, op_mdu: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

endpackage : lc3b_types

// ==== logic/control_decode.sv ====
`timescale 1ns/100ps

module control_decode import lc3b_types::*; (
	input lc3b_word ir,
	output lc3b_aluop aluop,
	output lc3b_alumux_sel alumux_sel,
	output logic reg_write,
	output logic is_store,
	output logic uses_sr2
);

lc3b_opcode opcode;

assign opcode = lc3b_opcode'(ir[15:12]);
assign reg_write = writes_dr(ir);

always_comb begin
	aluop = alu_pass;
	alumux_sel = sel_sr2;
	is_store = 1'b0;
	uses_sr2 = 1'b0;
	case (opcode)
		op_add: begin
			aluop = alu_add;
			alumux_sel = ir[5] ? sel_sext5 : sel_sr2;   // Bit 5 picks imm5
			uses_sr2 = ~ir[5];
		end
		op_and: begin
			aluop = alu_and;
			alumux_sel = ir[5] ? sel_sext5 : sel_sr2;
			uses_sr2 = ~ir[5];
		end
		op_not: aluop = alu_not;
		op_shf: begin
			alumux_sel = sel_zext4;
			if (!ir[4])
				aluop = alu_sll;
			else if (ir[5])
				aluop = alu_sra;
			else
				aluop = alu_srl;
		end
		op_str: begin
			aluop = alu_add;                            // Base plus adjusted offset
			alumux_sel = sel_adj6;
			is_store = 1'b1;
		end
		op_mdu: begin
			aluop = ir[5] ? alu_div : alu_mult;
			uses_sr2 = 1'b1;
		end
		default: ;
	endcase
end

endmodule : control_decode

// ==== logic/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen import lc3b_types::*; (
	input lc3b_word ir,
	input lc3b_word sr2_val,
	input lc3b_alumux_sel alumux_sel,
	output lc3b_word b_operand
);

lc3b_imm4 imm4;
lc3b_imm5 imm5;
lc3b_offset6 offset6;
lc3b_word sext5;
lc3b_word zext4;
lc3b_word adj6;

assign imm4 = ir[3:0];
assign imm5 = ir[4:0];
assign offset6 = ir[5:0];

assign sext5 = {{11{imm5[4]}}, imm5};
assign zext4 = {12'h000, imm4};                 // Shift amount
assign adj6 = {{9{offset6[5]}}, offset6, 1'b0};  // Word offset in bytes

always_comb begin
	case (alumux_sel)
		sel_sext5: b_operand = sext5;
		sel_adj6: b_operand = adj6;
		sel_zext4: b_operand = zext4;
		default: b_operand = sr2_val;
	endcase
end

endmodule : imm_gen

// ==== logic/forward_unit.sv ====
`timescale 1ns/100ps

module forward_unit import lc3b_types::*; (
	input lc3b_word ir,
	input logic uses_sr2,
	input logic is_store,
	input lc3b_word ex_mem_ir,
	input logic ex_mem_valid,
	input lc3b_word mem_wb_ir,
	input logic mem_wb_valid,
	output logic sr1_fwd,
	output logic sr1_from_wb,
	output logic sr2_fwd,
	output logic sr2_from_wb,
	output logic st_fwd,
	output logic st_from_wb
);

lc3b_reg sr1;
lc3b_reg sr2;
lc3b_reg st_src;
lc3b_reg ex_mem_dr;
lc3b_reg mem_wb_dr;
logic ex_mem_wr;
logic mem_wb_wr;
logic sr1_ex, sr1_wb;
logic sr2_ex, sr2_wb;
logic st_ex, st_wb;

assign sr1 = ir[8:6];
assign sr2 = ir[2:0];
assign st_src = ir[11:9];                       // STR source sits in the DR field

assign ex_mem_dr = ex_mem_ir[11:9];
assign mem_wb_dr = mem_wb_ir[11:9];
assign ex_mem_wr = ex_mem_valid && writes_dr(ex_mem_ir);
assign mem_wb_wr = mem_wb_valid && writes_dr(mem_wb_ir);

assign sr1_ex = ex_mem_wr && (ex_mem_dr == sr1);
assign sr1_wb = mem_wb_wr && (mem_wb_dr == sr1);
assign sr2_ex = uses_sr2 && ex_mem_wr && (ex_mem_dr == sr2);
assign sr2_wb = uses_sr2 && mem_wb_wr && (mem_wb_dr == sr2);
assign st_ex = is_store && ex_mem_wr && (ex_mem_dr == st_src);
assign st_wb = is_store && mem_wb_wr && (mem_wb_dr == st_src);

// Younger result in EX/MEM has priority
assign sr1_fwd = sr1_ex || sr1_wb;
assign sr1_from_wb = sr1_wb && !sr1_ex;
assign sr2_fwd = sr2_ex || sr2_wb;
assign sr2_from_wb = sr2_wb && !sr2_ex;
assign st_fwd = st_ex || st_wb;
assign st_from_wb = st_wb && !st_ex;

endmodule : forward_unit

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu import lc3b_types::*; (
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

logic [3:0] shamt;

assign shamt = b[3:0];

always_comb begin
	case (aluop)
		alu_add: f = a + b;
		alu_and: f = a & b;
		alu_not: f = ~a;
		alu_sll: f = a << shamt;
		alu_srl: f = a >> shamt;
		alu_sra: f = lc3b_word'($signed(a) >>> shamt);
		alu_pass: f = a;
		default: f = a;                             // MUL/DIV result comes from the MDU
	endcase
end

endmodule : alu

// ==== logic/mult_div_unit.sv ====
`timescale 1ns/100ps

module mult_div_unit import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input logic start_valid,
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word solution,
	output logic stall
);

logic busy;
logic op_div;
logic [mdu_cnt_w-1:0] count;
lc3b_word acc;                                  // Product, or dividend becoming quotient
lc3b_word rem;                                  // Partial remainder
lc3b_word opa;                                  // Multiplier
lc3b_word opb;                                  // Multiplicand or divisor
logic is_mdu;
logic start;
logic done;
lc3b_word acc_nxt;
lc3b_word rem_nxt;
logic [16:0] rem_sh;
logic [17:0] diff;

assign is_mdu = (aluop == alu_mult) || (aluop == alu_div);
assign start = start_valid && is_mdu && !busy;
assign done = busy && (count == mdu_cnt_w'(mdu_steps - 1));
assign stall = start_valid && is_mdu && !done;

assign rem_sh = {rem, acc[15]};
assign diff = {1'b0, rem_sh} - {2'b00, opb};

// One shift-add or restoring step
always_comb begin
	if (op_div) begin
		if (diff[17]) begin
			rem_nxt = rem_sh[15:0];
			acc_nxt = {acc[14:0], 1'b0};
		end else begin
			rem_nxt = diff[15:0];
			acc_nxt = {acc[14:0], 1'b1};           // Zero divisor ends as 0xFFFF
		end
	end else begin
		rem_nxt = rem;
		acc_nxt = opa[0] ? acc + opb : acc;
	end
end

assign solution = acc_nxt;                      // Last step lands in the done cycle

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
		count <= '0;
	end else if (start) begin
		busy <= 1'b1;
		count <= '0;
	end else if (busy) begin
		busy <= !done;
		count <= count + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (start) begin
		op_div <= (aluop == alu_div);
		acc <= (aluop == alu_div) ? a : '0;
		rem <= '0;
		opa <= a;
		opb <= b;
	end else if (busy) begin
		acc <= acc_nxt;
		rem <= rem_nxt;
		opa <= opa >> 1;
		opb <= op_div ? opb : opb << 1;
	end
end

endmodule : mult_div_unit

// ==== logic/execution_module.sv ====
`timescale 1ns/100ps

module execution_module import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input logic ex_valid,
	input lc3b_word curr_ir,
	input lc3b_word sr1_val,
	input lc3b_word sr2_val,
	input lc3b_aluop aluop,
	input lc3b_alumux_sel alumux_sel,
	input logic uses_sr2,
	input logic is_store,
	input lc3b_word ex_mem_ir,
	input lc3b_word ex_mem_val,
	input logic ex_mem_valid,
	input lc3b_word mem_wb_ir,
	input lc3b_word mem_wb_val,
	input logic mem_wb_valid,
	output lc3b_word alu_out,
	output lc3b_word ex_store_data,
	output logic stall
);

logic sr1_fwd, sr1_from_wb;
logic sr2_fwd, sr2_from_wb;
logic st_fwd, st_from_wb;
lc3b_word sr1_op;
lc3b_word sr2_op;
lc3b_word b_operand;
lc3b_word alu_f;
lc3b_word mdu_f;

function automatic lc3b_word pick(
	logic fwd,
	logic from_wb,
	lc3b_word own,
	lc3b_word ex_val,
	lc3b_word wb_val
);
	if (!fwd)
		return own;
	return from_wb ? wb_val : ex_val;
endfunction

forward_unit fwd_i (
	.ir(curr_ir), .uses_sr2(uses_sr2), .is_store(is_store),
	.ex_mem_ir(ex_mem_ir), .ex_mem_valid(ex_mem_valid),
	.mem_wb_ir(mem_wb_ir), .mem_wb_valid(mem_wb_valid),
	.sr1_fwd(sr1_fwd), .sr1_from_wb(sr1_from_wb),
	.sr2_fwd(sr2_fwd), .sr2_from_wb(sr2_from_wb),
	.st_fwd(st_fwd), .st_from_wb(st_from_wb)
);

assign sr1_op = pick(sr1_fwd, sr1_from_wb, sr1_val, ex_mem_val, mem_wb_val);
assign sr2_op = pick(sr2_fwd, sr2_from_wb, sr2_val, ex_mem_val, mem_wb_val);
assign ex_store_data = pick(st_fwd, st_from_wb, sr2_val, ex_mem_val, mem_wb_val);

imm_gen imm_i (
	.ir(curr_ir), .sr2_val(sr2_op), .alumux_sel(alumux_sel), .b_operand(b_operand)
);

alu alu_i (
	.aluop(aluop), .a(sr1_op), .b(b_operand), .f(alu_f)
);

mult_div_unit mdu_i (
	.clk(clk), .rst_n(rst_n), .start_valid(ex_valid), .aluop(aluop),
	.a(sr1_op), .b(b_operand), .solution(mdu_f), .stall(stall)
);

assign alu_out = (aluop == alu_mult || aluop == alu_div) ? mdu_f : alu_f;

endmodule : execution_module

// ==== logic/lc3b_ex_pipe.sv ====
`timescale 1ns/100ps

module lc3b_ex_pipe import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_word instr,
	input logic instr_valid,
	output logic instr_ready,
	output logic wb_valid,
	output lc3b_reg wb_reg,
	output lc3b_word wb_value,
	output logic st_valid,
	output lc3b_word st_addr,
	output lc3b_word st_data
);

lc3b_word regs [reg_count];
lc3b_aluop dec_aluop;
lc3b_alumux_sel dec_alumux_sel;
logic dec_reg_write, dec_is_store, dec_uses_sr2;
lc3b_reg sr1_idx, sr2_idx;
lc3b_word sr1_rd, sr2_rd;
logic accept, stall, rf_we;
lc3b_word alu_out, ex_store_data;

logic id_ex_valid;
lc3b_word id_ex_ir, id_ex_sr1, id_ex_sr2;
lc3b_aluop id_ex_aluop;
lc3b_alumux_sel id_ex_alumux_sel;
logic id_ex_reg_write, id_ex_is_store, id_ex_uses_sr2;

logic ex_mem_valid, ex_mem_reg_write, ex_mem_is_store;
lc3b_word ex_mem_ir, ex_mem_val, ex_mem_st_data;

logic mem_wb_valid, mem_wb_reg_write;
lc3b_word mem_wb_ir, mem_wb_val;

control_decode decode_i (
	.ir(instr), .aluop(dec_aluop), .alumux_sel(dec_alumux_sel),
	.reg_write(dec_reg_write), .is_store(dec_is_store), .uses_sr2(dec_uses_sr2)
);

assign instr_ready = ~stall;
assign accept = instr_valid && instr_ready;
assign rf_we = mem_wb_valid && mem_wb_reg_write;

assign sr1_idx = instr[8:6];
assign sr2_idx = dec_is_store ? instr[11:9] : instr[2:0];
// Write-through on a same-cycle write
assign sr1_rd = (rf_we && mem_wb_ir[11:9] == sr1_idx) ? mem_wb_val : regs[sr1_idx];
assign sr2_rd = (rf_we && mem_wb_ir[11:9] == sr2_idx) ? mem_wb_val : regs[sr2_idx];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < reg_count; i++)
			regs[i] <= '0;
	end else if (rf_we) begin
		regs[mem_wb_ir[11:9]] <= mem_wb_val;
	end
end

execution_module ex_i (
	.clk(clk), .rst_n(rst_n), .ex_valid(id_ex_valid), .curr_ir(id_ex_ir),
	.sr1_val(id_ex_sr1), .sr2_val(id_ex_sr2), .aluop(id_ex_aluop),
	.alumux_sel(id_ex_alumux_sel), .uses_sr2(id_ex_uses_sr2), .is_store(id_ex_is_store),
	.ex_mem_ir(ex_mem_ir), .ex_mem_val(ex_mem_val), .ex_mem_valid(ex_mem_valid),
	.mem_wb_ir(mem_wb_ir), .mem_wb_val(mem_wb_val), .mem_wb_valid(mem_wb_valid),
	.alu_out(alu_out), .ex_store_data(ex_store_data), .stall(stall)
);

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		id_ex_valid <= 1'b0;
		ex_mem_valid <= 1'b0;
		mem_wb_valid <= 1'b0;
	end else begin
		if (!stall)
			id_ex_valid <= instr_valid;             // ID/EX holds during a stall
		ex_mem_valid <= id_ex_valid && !stall;     // Bubble while MUL/DIV iterates
		mem_wb_valid <= ex_mem_valid;
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		id_ex_ir <= instr;
		id_ex_sr1 <= sr1_rd;
		id_ex_sr2 <= sr2_rd;
		id_ex_aluop <= dec_aluop;
		id_ex_alumux_sel <= dec_alumux_sel;
		id_ex_reg_write <= dec_reg_write;
		id_ex_is_store <= dec_is_store;
		id_ex_uses_sr2 <= dec_uses_sr2;
	end
	ex_mem_ir <= id_ex_ir;
	ex_mem_val <= alu_out;
	ex_mem_st_data <= ex_store_data;
	ex_mem_reg_write <= id_ex_reg_write;
	ex_mem_is_store <= id_ex_is_store;
	mem_wb_ir <= ex_mem_ir;
	mem_wb_val <= ex_mem_val;
	mem_wb_reg_write <= ex_mem_reg_write;
end

assign wb_valid = rf_we;
assign wb_reg = mem_wb_ir[11:9];
assign wb_value = mem_wb_val;
assign st_valid = ex_mem_valid && ex_mem_is_store;
assign st_addr = ex_mem_val;
assign st_data = ex_mem_st_data;

endmodule : lc3b_ex_pipe

// ==== bench/tb_lc3b_ex_pipe.sv ====
`timescale 1ns/100ps

module tb_lc3b_ex_pipe;

logic clk;
logic rst_n;
logic [15:0] instr;
logic instr_valid;
logic instr_ready;
logic wb_valid;
logic [2:0] wb_reg;
logic [15:0] wb_value;
logic st_valid;
logic [15:0] st_addr;
logic [15:0] st_data;

logic [15:0] model_rf [8];
logic [18:0] wb_q [$];                          // {reg, value}
logic [31:0] st_q [$];                          // {addr, data}
int stall_cycles;

lc3b_ex_pipe lc3b_ex_pipe_i (
	.clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
	.instr_ready(instr_ready), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_value(wb_value),
	.st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
);

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

task automatic fail_run(input string why);
	if (why.len() != 0)
		$display("%s", why);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
	$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
	fail_run("");
endtask

function automatic logic [15:0] reg_form(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [2:0] sr2);
	return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic logic [15:0] imm_form(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [4:0] imm5);
	return {op, dr, sr1, 1'b1, imm5};
endfunction

function automatic logic [15:0] not_instr(input logic [2:0] dr, input logic [2:0] sr);
	return {4'b1001, dr, sr, 6'h3f};
endfunction

// Kind 00 left, 01 logical right, 11 arithmetic right
function automatic logic [15:0] shift_instr(input logic [2:0] dr, input logic [2:0] sr,
		input logic [1:0] kind, input logic [3:0] amt);
	return {4'b1010, dr, sr, kind, amt};
endfunction

function automatic logic [15:0] store_instr(input logic [2:0] sr, input logic [2:0] base,
		input logic [5:0] off6);
	return {4'b0111, sr, base, off6};
endfunction

function automatic logic [15:0] muldiv_instr(input logic [2:0] dr, input logic [2:0] sr1,
		input logic div, input logic [2:0] sr2);
	return {4'b1101, dr, sr1, div, 2'b00, sr2};
endfunction

function automatic logic [15:0] random_instr();
	logic [31:0] r;
	r = $urandom();
	case (r[31:28])
		4'd0, 4'd1, 4'd2: return {r[27] ? 4'b0101 : 4'b0001, r[11:6], 3'b000, r[2:0]};
		4'd3, 4'd4, 4'd5: return {r[27] ? 4'b0101 : 4'b0001, r[11:6], 1'b1, r[4:0]};
		4'd6, 4'd7: return {4'b1001, r[11:6], 6'h3f};
		4'd8, 4'd9, 4'd10: return {4'b1010, r[11:0]};
		4'd11, 4'd12, 4'd13: return {4'b0111, r[11:0]};
		default: return {4'b1101, r[11:6], r[5], 2'b00, r[2:0]};
	endcase
endfunction

// Architectural effect of one instruction in program order
task automatic apply_model(input logic [15:0] ir);
	logic [15:0] a;
	logic [15:0] r2;
	logic [15:0] imm5;
	logic [15:0] off;
	logic [15:0] res;
	logic [3:0] amt;
	a = model_rf[ir[8:6]];
	r2 = model_rf[ir[2:0]];
	imm5 = {{11{ir[4]}}, ir[4:0]};
	off = {{9{ir[5]}}, ir[5:0], 1'b0};
	amt = ir[3:0];
	res = 16'h0000;
	case (ir[15:12])
		4'b0001: res = a + (ir[5] ? imm5 : r2);
		4'b0101: res = a & (ir[5] ? imm5 : r2);
		4'b1001: res = ~a;
		4'b1010: begin
			if (!ir[4])
				res = a << amt;
			else if (!ir[5])
				res = a >> amt;
			else
				res = $signed(a) >>> amt;
		end
		4'b1101: begin
			if (!ir[5])
				res = a * r2;                           // Low half of the product
			else if (r2 == 16'h0000)
				res = 16'hffff;
			else
				res = a / r2;
		end
		default: ;
	endcase
	if (ir[15:12] == 4'b0111) begin
		st_q.push_back({a + off, model_rf[ir[11:9]]});
	end else begin
		model_rf[ir[11:9]] = res;
		wb_q.push_back({ir[11:9], res});
	end
endtask

// Result checks against the model, then the accepted instruction
always @(posedge clk) begin
	logic [18:0] wb_exp;
	logic [31:0] st_exp;
	if (rst_n) begin
		if (wb_valid) begin
			assert (wb_q.size() > 0) else fail_run("write-back seen with none expected");
			wb_exp = wb_q.pop_front();
			assert (wb_reg == wb_exp[18:16])
				else report_mismatch("wb_reg", {13'b0, wb_reg}, {13'b0, wb_exp[18:16]});
			assert (wb_value == wb_exp[15:0])
				else report_mismatch("wb_value", wb_value, wb_exp[15:0]);
		end
		if (st_valid) begin
			assert (st_q.size() > 0) else fail_run("store seen with none expected");
			st_exp = st_q.pop_front();
			assert (st_addr == st_exp[31:16])
				else report_mismatch("st_addr", st_addr, st_exp[31:16]);
			assert (st_data == st_exp[15:0])
				else report_mismatch("st_data", st_data, st_exp[15:0]);
		end
		if (instr_valid && !instr_ready)
			stall_cycles++;
		if (instr_valid && instr_ready)
			apply_model(instr);
	end
end

task automatic issue(input logic [15:0] ir);
	int waited;
	waited = 0;
	instr <= ir;
	instr_valid <= 1'b1;
	do begin
		@(posedge clk);
		waited++;
		if (waited > 100)
			fail_run("timeout waiting for instr_ready");
	end while (!instr_ready);
	instr_valid <= 1'b0;
endtask

initial begin
	int gap;
	int waited;
	void'($urandom(51346));
	rst_n = 1'b0;
	instr = 16'h0000;
	instr_valid = 1'b0;
	stall_cycles = 0;
	for (int i = 0; i < 8; i++)
		model_rf[i] = 16'h0000;
	repeat (5) @(posedge clk);
	rst_n <= 1'b1;
	repeat (3) @(posedge clk);
	assert (instr_ready) else fail_run("instr_ready low after reset");
	assert (!wb_valid && !st_valid) else fail_run("result valid before any instruction");

	issue(imm_form(4'b0001, 3'd1, 3'd0, 5'd7));
	issue(imm_form(4'b0001, 3'd2, 3'd1, 5'h1d));  // Distance one
	issue(reg_form(4'b0001, 3'd3, 3'd1, 3'd2));   // Distances two and one
	issue(reg_form(4'b0101, 3'd4, 3'd3, 3'd1));
	issue(not_instr(3'd5, 3'd4));
	issue(reg_form(4'b0001, 3'd6, 3'd5, 3'd3));   // R3 read through the register file
	issue(imm_form(4'b0101, 3'd7, 3'd6, 5'h0f));
	issue(reg_form(4'b0001, 3'd1, 3'd1, 3'd1));

	issue(shift_instr(3'd1, 3'd5, 2'b00, 4'd3));
	issue(shift_instr(3'd2, 3'd5, 2'b01, 4'd4));
	issue(shift_instr(3'd3, 3'd5, 2'b11, 4'd2));
	issue(shift_instr(3'd4, 3'd1, 2'b11, 4'd15));

	issue(imm_form(4'b0001, 3'd1, 3'd0, 5'd13));
	issue(imm_form(4'b0001, 3'd2, 3'd0, 5'h1a));
	issue(muldiv_instr(3'd3, 3'd1, 1'b0, 3'd2));
	issue(imm_form(4'b0001, 3'd4, 3'd3, 5'd1));   // Needs the product
	issue(muldiv_instr(3'd4, 3'd2, 1'b1, 3'd1));
	issue(muldiv_instr(3'd5, 3'd1, 1'b1, 3'd0));  // R0 still zero
	issue(reg_form(4'b0001, 3'd6, 3'd5, 3'd4));
	assert (stall_cycles > 0) else fail_run("instr_ready never dropped for MUL/DIV");

	issue(imm_form(4'b0001, 3'd7, 3'd0, 5'd8));
	issue(store_instr(3'd7, 3'd7, 6'h3e));        // Base and data both just produced
	issue(imm_form(4'b0001, 3'd1, 3'd3, 5'd5));
	issue(store_instr(3'd1, 3'd7, 6'h05));
	issue(store_instr(3'd6, 3'd2, 6'h20));

	for (int n = 0; n < 300; n++) begin
		issue(random_instr());
		gap = int'($urandom % 4);
		if (gap > 1)
			repeat (gap - 1) @(posedge clk);
	end

	waited = 0;
	while (wb_q.size() != 0 || st_q.size() != 0) begin
		@(posedge clk);
		waited++;
		if (waited > 200)
			fail_run("timeout waiting for the pipeline to drain");
	end
	repeat (5) @(posedge clk);
	$display("TEST OK");
	$finish;
end

endmodule : tb_lc3b_ex_pipe

// ==== lc3b_execute.f ====
logic/lc3b_types.sv
logic/control_decode.sv
logic/imm_gen.sv
logic/forward_unit.sv
logic/alu.sv
logic/mult_div_unit.sv
logic/execution_module.sv
logic/lc3b_ex_pipe.sv
bench/tb_lc3b_ex_pipe.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_lc3b_ex_pipe -f lc3b_execute.f
	./obj_dir/Vtb_lc3b_ex_pipe | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module tb_lc3b_ex_pipe -f lc3b_execute.f

clean:
	rm -rf obj_dir $(LOG)
